/* design/sublane_driver_pkg.sv */
`default_nettype none

package sublane_driver_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////
   localparam int LANE_NUM        = 8;
   localparam int LANE_W          = $clog2(LANE_NUM);
   localparam int MEM_DEPTH       = 512;                      // words per lane vrf
   localparam int ADDR_W          = $clog2(MEM_DEPTH);
   localparam int MAX_VL_PER_LANE = 256;
   localparam int ELEM_W          = $clog2(MAX_VL_PER_LANE);  // element index in a lane
   localparam int VL_W            = $clog2(LANE_NUM * MAX_VL_PER_LANE);
   localparam int BYTES_PER_WORD  = 4;
   localparam int RCNT_W          = ELEM_W + 1;               // holds a full 256 count
   localparam int CYC_W           = ELEM_W + 2;               // reads + delay + tail

   ////////////////////////////////////////////////////////////////////////////
   // encodings
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      BYTE = 2'd0,
      HALF = 2'd1,
      WORD = 2'd2
   } sew_e;

   typedef enum logic [2:0] {
      NORMAL        = 3'd0,
      STORE         = 3'd2,
      INDEXED_STORE = 3'd3,
      LOAD          = 3'd4
   } inst_type_e;

   ////////////////////////////////////////////////////////////////////////////
   // port bundles
   ////////////////////////////////////////////////////////////////////////////
   typedef logic [BYTES_PER_WORD-1:0] byte_en_t;
   typedef byte_en_t [LANE_NUM-1:0] lane_bwen_t;

   typedef struct packed {
      inst_type_e                inst_type;
      logic [VL_W-1:0]           vl;
      sew_e                      sew;
      logic [ELEM_W-1:0]         inst_delay;   // cycles from first read to first write
      logic [ADDR_W-1:0]         waddr_start;
      logic [1:0][ADDR_W-1:0]    raddr_start;
   } sublane_cmd_t;

   typedef struct packed {
      logic       valid;
      logic       last;
      lane_bwen_t lane_bwen;
   } load_beat_t;

   typedef struct packed {
      logic                   ren;
      logic [1:0][ADDR_W-1:0] raddr;
      sew_e                   sew;
   } vrf_read_t;

   typedef struct packed {
      logic              wen;
      logic [ADDR_W-1:0] waddr;
      lane_bwen_t        bwen;
      logic              from_load;   // 1 = load data, 0 = alu data
   } vrf_write_t;

   typedef struct packed {
      logic data_valid;
      logic index_valid;
   } store_ctrl_t;

endpackage

`default_nettype wire

/* design/vrf_addr_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module vrf_addr_counter (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 load_i,
   input  logic [sublane_driver_pkg::ADDR_W-1:0] start_addr_i,
   input  sublane_driver_pkg::sew_e             sew_i,
   input  logic                                 en_i,
   input  logic                                 clear_i,
   output logic [sublane_driver_pkg::ADDR_W-1:0] addr_o,
   output logic [sublane_driver_pkg::ELEM_W-1:0] elem_o
);
   import sublane_driver_pkg::*;

   logic [1:0] wrap_mask;
   logic [1:0] sub_cnt;
   logic       word_step;

   // elements per word minus one
   always_comb begin
      case (sew_i)
         BYTE:    wrap_mask = 2'b11;
         HALF:    wrap_mask = 2'b01;
         default: wrap_mask = 2'b00;
      endcase
   end

   // sub-word position comes from the low element bits
   assign sub_cnt   = elem_o[1:0] & wrap_mask;
   assign word_step = (sub_cnt == wrap_mask);   // last element of this word

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         addr_o <= '0;
         elem_o <= '0;
      end else if (load_i) begin
         addr_o <= start_addr_i;
         elem_o <= '0;
      end else if (clear_i) begin
         addr_o <= '0;
         elem_o <= '0;
      end else if (en_i) begin
         elem_o <= elem_o + 1'b1;
         if (word_step) begin
            addr_o <= addr_o + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* design/byte_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_enable_gen (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic                               en_i,
   input  logic                               clear_i,
   input  sublane_driver_pkg::sew_e           sew_i,
   input  logic [sublane_driver_pkg::VL_W-1:0] vl_i,
   output sublane_driver_pkg::lane_bwen_t     bwen_o
);
   import sublane_driver_pkg::*;

   logic [ELEM_W-1:0] elem_q;    // element index k, same in every lane
   byte_en_t          shift4_q;  // one-hot, byte k mod 4
   logic [1:0]        shift2_q;  // half k mod 2
   byte_en_t          word_sel;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         elem_q   <= '0;
         shift4_q <= 4'b0001;
         shift2_q <= 2'b01;
      end else if (clear_i) begin
         elem_q   <= '0;
         shift4_q <= 4'b0001;
         shift2_q <= 2'b01;
      end else if (en_i) begin
         elem_q   <= elem_q + 1'b1;
         shift4_q <= {shift4_q[2:0], shift4_q[3]};
         shift2_q <= {shift2_q[0], shift2_q[1]};
      end
   end

   always_comb begin
      case (sew_i)
         BYTE:    word_sel = shift4_q;
         HALF:    word_sel = {{2{shift2_q[1]}}, {2{shift2_q[0]}}};
         WORD:    word_sel = '1;
         default: word_sel = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // tail masking
   ////////////////////////////////////////////////////////////////////////////
   // global element of a lane is k*LANE_NUM + lane
   always_comb begin
      for (int lane = 0; lane < LANE_NUM; lane++) begin
         if ({elem_q, LANE_W'(lane)} < vl_i) begin
            bwen_o[lane] = word_sel;
         end else begin
            bwen_o[lane] = '0;   // past vl
         end
      end
   end

endmodule

`default_nettype wire

/* design/sublane_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module sublane_ctrl_fsm (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             start_i,
   input  sublane_driver_pkg::sublane_cmd_t cmd_i,
   input  sublane_driver_pkg::load_beat_t   load_i,
   output logic                             ready_o,
   output logic                             ready_for_load_o,
   output sublane_driver_pkg::sublane_cmd_t cmd_o,
   output logic                             rd_cnt_en_o,
   output logic                             wr_cnt_en_o,
   output logic                             cnt_load_o,
   output logic                             cnt_clear_o,
   output logic                             ren_o,
   output logic                             wen_o,
   output logic                             from_load_o,
   output sublane_driver_pkg::store_ctrl_t  store_o
);
   import sublane_driver_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      NORMAL_RUN,
      READ_RUN,
      LOAD_RUN
   } state_e;

   state_e            state_q;
   logic [RCNT_W-1:0] r_q;        // elements per lane, ceil(vl / LANE_NUM)
   logic [CYC_W-1:0]  cyc_q;
   logic [CYC_W-1:0]  rd_last;
   logic [CYC_W-1:0]  wr_first;
   logic [CYC_W-1:0]  wr_last;
   logic              accept;
   logic              rd_win;
   logic              wr_win;
   logic              load_take;
   logic              finish;
   logic              is_store;

   assign accept    = start_i && ready_o;
   assign load_take = ready_for_load_o && load_i.valid;
   assign is_store  = (cmd_o.inst_type == STORE) || (cmd_o.inst_type == INDEXED_STORE);

   ////////////////////////////////////////////////////////////////////////////
   // read / write windows on the cycle counter
   ////////////////////////////////////////////////////////////////////////////
   assign rd_last  = CYC_W'(r_q);
   assign wr_first = CYC_W'(cmd_o.inst_delay) + 1'b1;
   assign wr_last  = CYC_W'(r_q) + CYC_W'(cmd_o.inst_delay);
   assign rd_win   = (cyc_q != '0) && (cyc_q <= rd_last);     // cycles 1..R
   assign wr_win   = (cyc_q >= wr_first) && (cyc_q <= wr_last);

   always_comb begin
      case (state_q)
         NORMAL_RUN: finish = (cyc_q == wr_last + 1'b1);   // one after last write
         READ_RUN:   finish = (cyc_q == rd_last + 1'b1);
         LOAD_RUN:   finish = (cyc_q == CYC_W'(2)) && !ready_for_load_o;
         default:    finish = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // state, command register, cycle counter
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= IDLE;
         cmd_o   <= '0;
         r_q     <= '0;
         cyc_q   <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (accept) begin
                  cmd_o <= cmd_i;
                  r_q   <= {1'b0, cmd_i.vl[VL_W-1:LANE_W]} + RCNT_W'(|cmd_i.vl[LANE_W-1:0]);
                  cyc_q <= '0;
                  case (cmd_i.inst_type)
                     NORMAL: state_q <= NORMAL_RUN;
                     LOAD: begin
                        state_q   <= LOAD_RUN;
                        cmd_o.sew <= WORD;       // load beats fill whole words
                     end
                     default: state_q <= READ_RUN;
                  endcase
               end
            end
            default: begin
               if (finish) begin
                  state_q <= IDLE;
               end
               // in a load the counter parks at 2 while beats are taken
               if (state_q != LOAD_RUN || !ready_for_load_o) begin
                  cyc_q <= cyc_q + 1'b1;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // registered outputs
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ready_o          <= 1'b1;
         ready_for_load_o <= 1'b0;
         ren_o            <= 1'b0;
         wen_o            <= 1'b0;
         from_load_o      <= 1'b0;
         cnt_load_o       <= 1'b0;
         cnt_clear_o      <= 1'b0;
         store_o          <= '0;
      end else begin
         if (accept) begin
            ready_o <= 1'b0;
         end else if (finish) begin
            ready_o <= 1'b1;
         end
         cnt_load_o  <= accept;   // counters take start addresses at cycle 0
         cnt_clear_o <= finish;
         ren_o       <= (state_q == NORMAL_RUN || state_q == READ_RUN) && rd_win;
         wen_o       <= (state_q == NORMAL_RUN && wr_win) || load_take;
         from_load_o <= load_take;
         ready_for_load_o <= (state_q == LOAD_RUN) &&
                             ((cyc_q == CYC_W'(1)) ||
                              (ready_for_load_o && !(load_take && load_i.last)));
         store_o.data_valid  <= (state_q == READ_RUN) && rd_win && is_store;
         store_o.index_valid <= (state_q == READ_RUN) && rd_win &&
                                (cmd_o.inst_type == INDEXED_STORE);
      end
   end

   // address counters step on every issued access
   assign rd_cnt_en_o = ren_o;
   assign wr_cnt_en_o = wen_o;

endmodule

`default_nettype wire

/* design/sublane_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module sublane_driver (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic                             start_i,
   input  sublane_driver_pkg::sublane_cmd_t cmd_i,
   input  sublane_driver_pkg::load_beat_t   load_i,
   output logic                             ready_o,
   output logic                             ready_for_load_o,
   output sublane_driver_pkg::vrf_read_t    vrf_rd_o,
   output sublane_driver_pkg::vrf_write_t   vrf_wr_o,
   output sublane_driver_pkg::store_ctrl_t  store_o
);
   import sublane_driver_pkg::*;

   sublane_cmd_t      cmd_q;
   logic              rd_cnt_en;
   logic              wr_cnt_en;
   logic              cnt_load;
   logic              cnt_clear;
   logic              ren;
   logic              wen;
   logic              from_load;
   logic [ADDR_W-1:0] waddr;
   logic [ADDR_W-1:0] raddr0;
   logic [ADDR_W-1:0] raddr1;
   lane_bwen_t        gen_bwen;
   lane_bwen_t        load_bwen_q;

   sublane_ctrl_fsm i_ctrl_fsm (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .start_i          (start_i),
      .cmd_i            (cmd_i),
      .load_i           (load_i),
      .ready_o          (ready_o),
      .ready_for_load_o (ready_for_load_o),
      .cmd_o            (cmd_q),
      .rd_cnt_en_o      (rd_cnt_en),
      .wr_cnt_en_o      (wr_cnt_en),
      .cnt_load_o       (cnt_load),
      .cnt_clear_o      (cnt_clear),
      .ren_o            (ren),
      .wen_o            (wen),
      .from_load_o      (from_load),
      .store_o          (store_o)
   );

   vrf_addr_counter i_waddr_cnt (
      .clk_i (clk_i), .rst_i (rst_i), .load_i (cnt_load),
      .start_addr_i (cmd_q.waddr_start), .sew_i (cmd_q.sew),
      .en_i (wr_cnt_en), .clear_i (cnt_clear), .addr_o (waddr), .elem_o ()
   );

   vrf_addr_counter i_raddr0_cnt (
      .clk_i (clk_i), .rst_i (rst_i), .load_i (cnt_load),
      .start_addr_i (cmd_q.raddr_start[0]), .sew_i (cmd_q.sew),
      .en_i (rd_cnt_en), .clear_i (cnt_clear), .addr_o (raddr0), .elem_o ()
   );

   vrf_addr_counter i_raddr1_cnt (
      .clk_i (clk_i), .rst_i (rst_i), .load_i (cnt_load),
      .start_addr_i (cmd_q.raddr_start[1]), .sew_i (cmd_q.sew),
      .en_i (rd_cnt_en), .clear_i (cnt_clear), .addr_o (raddr1), .elem_o ()
   );

   byte_enable_gen i_bwen_gen (
      .clk_i (clk_i), .rst_i (rst_i), .en_i (wr_cnt_en), .clear_i (cnt_clear),
      .sew_i (cmd_q.sew), .vl_i (cmd_q.vl), .bwen_o (gen_bwen)
   );

   // beat enables held for the write issued one cycle later
   always_ff @(posedge clk_i) begin
      if (load_i.valid && ready_for_load_o) begin
         load_bwen_q <= load_i.lane_bwen;
      end
   end

   assign vrf_rd_o.ren      = ren;
   assign vrf_rd_o.raddr[0] = raddr0;
   assign vrf_rd_o.raddr[1] = raddr1;
   assign vrf_rd_o.sew      = cmd_q.sew;

   assign vrf_wr_o.wen       = wen;
   assign vrf_wr_o.waddr     = waddr;
   assign vrf_wr_o.bwen      = from_load ? load_bwen_q : gen_bwen;
   assign vrf_wr_o.from_load = from_load;

endmodule

`default_nettype wire

/* test/sublane_driver_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sublane_driver_tb;
   import sublane_driver_pkg::*;

   localparam int NUM_ROWS   = 11;
   localparam int WAIT_LIMIT = 2000;   // cycles per wait

   typedef struct packed {
      inst_type_e        kind;
      logic [VL_W-1:0]   vl;
      sew_e              sew;
      logic [ELEM_W-1:0] delay;
      logic [ADDR_W-1:0] waddr;
      logic [ADDR_W-1:0] raddr0;
      logic [ADDR_W-1:0] raddr1;
      logic [7:0]        beats;   // load only
   } row_t;

   logic         clk_i;
   logic         rst_i;
   logic         start_i;
   sublane_cmd_t cmd_i;
   load_beat_t   load_i;
   logic         ready_o;
   logic         ready_for_load_o;
   vrf_read_t    vrf_rd_o;
   vrf_write_t   vrf_wr_o;
   store_ctrl_t  store_o;

   row_t         rows [NUM_ROWS];
   int           cyc_cnt = 0;
   logic [31:0]  lcg_state;
   vrf_read_t    rd_q[$];       // accesses seen by the monitor
   store_ctrl_t  st_q[$];
   vrf_write_t   wr_q[$];
   int           rd_cyc_q[$];
   int           wr_cyc_q[$];
   lane_bwen_t   beat_q[$];     // load enables as driven

   sublane_driver i_dut (
      .clk_i (clk_i), .rst_i (rst_i), .start_i (start_i), .cmd_i (cmd_i), .load_i (load_i),
      .ready_o (ready_o), .ready_for_load_o (ready_for_load_o),
      .vrf_rd_o (vrf_rd_o), .vrf_wr_o (vrf_wr_o), .store_o (store_o)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

   task automatic stop_with_failure();
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic flag_mismatch(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      stop_with_failure();
   endtask

   task automatic abort_timeout(input string what);
      $display("Timed out while waiting for %s", what);
      stop_with_failure();
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 8;
   endfunction

   // element k of every lane, tail lanes past vl get nothing
   function automatic lane_bwen_t expect_bwen(input int k, input int sew, input int vl);
      lane_bwen_t b;
      for (int lane = 0; lane < LANE_NUM; lane++) begin
         if (k * LANE_NUM + lane >= vl) b[lane] = '0;
         else if (sew == 0) b[lane] = byte_en_t'(1 << (k % 4));
         else if (sew == 1) b[lane] = (k % 2 == 1) ? 4'b1100 : 4'b0011;
         else b[lane] = 4'b1111;
      end
      return b;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // monitor, sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge clk_i) begin
      if (rst_i) begin
         assert (!store_o.data_valid || vrf_rd_o.ren)
            else flag_mismatch("data_valid without a read");
         assert (!store_o.index_valid || store_o.data_valid)
            else flag_mismatch("index_valid without data_valid");
         if (vrf_rd_o.ren) begin
            rd_q.push_back(vrf_rd_o);
            st_q.push_back(store_o);
            rd_cyc_q.push_back(cyc_cnt);
         end
         if (vrf_wr_o.wen) begin
            wr_q.push_back(vrf_wr_o);
            wr_cyc_q.push_back(cyc_cnt);
         end
      end
   end

   task automatic wait_ready(output int seen_cyc);
      int guard;
      guard = 0;
      @(negedge clk_i);
      while (!ready_o) begin
         guard++;
         if (guard > WAIT_LIMIT) abort_timeout("ready_o to return");
         @(negedge clk_i);
      end
      seen_cyc = cyc_cnt;
   endtask

   // beats only while the DUT asks for them, with random gaps
   task automatic drive_loads(input int beats);
      int         sent;
      int         guard;
      lane_bwen_t bwen;
      sent  = 0;
      guard = 0;
      while (sent < beats) begin
         @(negedge clk_i);
         guard++;
         if (guard > WAIT_LIMIT) abort_timeout("ready_for_load_o");
         load_i = '0;
         if (ready_for_load_o && (next_rand() % 4 != 0)) begin
            bwen             = lane_bwen_t'(next_rand() << 16);   // reaches the upper lanes
            bwen             = bwen ^ lane_bwen_t'(next_rand());
            load_i.valid     = 1'b1;
            load_i.last      = (sent == beats - 1);
            load_i.lane_bwen = bwen;
            beat_q.push_back(bwen);
            sent++;
         end
      end
      @(negedge clk_i);
      load_i = '0;
      assert (!ready_for_load_o) else flag_mismatch("ready_for_load_o high after last beat");
   endtask

   task automatic check_row(input row_t r, input int acc_cyc, input int rdy_cyc);
      int n_r;
      int n_w;
      int step;
      int last;
      n_r  = (r.kind == LOAD) ? 0 : (int'(r.vl) + LANE_NUM - 1) / LANE_NUM;
      n_w  = (r.kind == NORMAL) ? n_r : ((r.kind == LOAD) ? int'(r.beats) : 0);
      step = 2 - int'(r.sew);   // log2 of elements per word
      assert (rd_q.size() == n_r)
         else flag_mismatch($sformatf("%0d reads, expected %0d", rd_q.size(), n_r));
      assert (wr_q.size() == n_w)
         else flag_mismatch($sformatf("%0d writes, expected %0d", wr_q.size(), n_w));
      for (int i = 0; i < n_r; i++) begin
         assert (rd_q[i].raddr[0] == ADDR_W'(int'(r.raddr0) + (i >> step)) &&
                 rd_q[i].raddr[1] == ADDR_W'(int'(r.raddr1) + (i >> step)) &&
                 rd_q[i].sew == r.sew)
            else flag_mismatch($sformatf("read %0d addresses %0d %0d sew %0d", i,
                                         rd_q[i].raddr[0], rd_q[i].raddr[1], rd_q[i].sew));
         assert (rd_cyc_q[i] == acc_cyc + 2 + i)   // cycle 1 after acceptance
            else flag_mismatch($sformatf("read %0d at cycle %0d", i, rd_cyc_q[i]));
         assert (st_q[i].data_valid == (r.kind != NORMAL) &&
                 st_q[i].index_valid == (r.kind == INDEXED_STORE))
            else flag_mismatch($sformatf("read %0d store flags %b", i, st_q[i]));
      end
      for (int i = 0; i < n_w; i++) begin
         if (r.kind == LOAD) begin
            assert (wr_q[i].waddr == ADDR_W'(int'(r.waddr) + i) && wr_q[i].from_load &&
                    wr_q[i].bwen == beat_q[i])
               else flag_mismatch($sformatf("load write %0d addr %0d bwen %h", i,
                                            wr_q[i].waddr, wr_q[i].bwen));
         end else begin
            assert (wr_q[i].waddr == ADDR_W'(int'(r.waddr) + (i >> step)) &&
                    !wr_q[i].from_load &&
                    wr_q[i].bwen == expect_bwen(i, int'(r.sew), int'(r.vl)))
               else flag_mismatch($sformatf("write %0d addr %0d bwen %h", i,
                                            wr_q[i].waddr, wr_q[i].bwen));
            assert (wr_cyc_q[i] == rd_cyc_q[0] + int'(r.delay) + i)
               else flag_mismatch($sformatf("write %0d at cycle %0d", i, wr_cyc_q[i]));
         end
      end
      last = (n_w > 0) ? wr_cyc_q[n_w-1] : rd_cyc_q[n_r-1];
      assert (rdy_cyc == last + 1)
         else flag_mismatch($sformatf("ready_o back at %0d, last access %0d", rdy_cyc, last));
   endtask

   // entered at a falling edge with ready_o high, so rows run back to back
   task automatic run_row(input row_t r);
      sublane_cmd_t cmd;
      int           acc_cyc;
      int           rdy_cyc;
      rd_q.delete();
      st_q.delete();
      wr_q.delete();
      rd_cyc_q.delete();
      wr_cyc_q.delete();
      beat_q.delete();
      cmd.inst_type      = r.kind;
      cmd.vl             = r.vl;
      cmd.sew            = r.sew;
      cmd.inst_delay     = r.delay;
      cmd.waddr_start    = r.waddr;
      cmd.raddr_start[0] = r.raddr0;
      cmd.raddr_start[1] = r.raddr1;
      assert (ready_o) else flag_mismatch("ready_o low before start");
      start_i = 1'b1;
      cmd_i   = cmd;
      @(negedge clk_i);
      acc_cyc = cyc_cnt;
      assert (!ready_o) else flag_mismatch("ready_o still high after acceptance");
      cmd_i = sublane_cmd_t'(~cmd);   // start held with another command
      @(negedge clk_i);
      start_i = 1'b0;
      assert (!ready_o) else flag_mismatch("ready_o high while busy");
      if (r.kind == LOAD) drive_loads(int'(r.beats));
      wait_ready(rdy_cyc);
      check_row(r, acc_cyc, rdy_cyc);
   endtask

   initial begin
      clk_i     = 1'b0;
      rst_i     = 1'b0;
      start_i   = 1'b0;
      cmd_i     = '0;
      load_i    = '0;
      lcg_state = 32'd8;
      //            kind           vl      sew   delay  waddr   raddr0  raddr1  beats
      rows[0]  = '{NORMAL,        11'd16, BYTE, 8'd3, 9'd10,  9'd20,  9'd40,  8'd0};
      rows[1]  = '{NORMAL,        11'd13, HALF, 8'd0, 9'd100, 9'd200, 9'd300, 8'd0};
      rows[2]  = '{NORMAL,        11'd24, WORD, 8'd5, 9'd60,  9'd70,  9'd80,  8'd0};
      rows[3]  = '{NORMAL,        11'd5,  BYTE, 8'd1, 9'd7,   9'd9,   9'd11,  8'd0};
      rows[4]  = '{NORMAL,        11'd35, WORD, 8'd2, 9'd30,  9'd130, 9'd230, 8'd0};
      rows[5]  = '{STORE,         11'd20, HALF, 8'd0, 9'd0,   9'd12,  9'd34,  8'd0};
      rows[6]  = '{INDEXED_STORE, 11'd9,  BYTE, 8'd0, 9'd0,   9'd56,  9'd78,  8'd0};
      rows[7]  = '{LOAD,          11'd0,  WORD, 8'd0, 9'd50,  9'd0,   9'd0,   8'd6};
      rows[8]  = '{NORMAL,        11'd8,  HALF, 8'd4, 9'd1,   9'd2,   9'd3,   8'd0};
      rows[9]  = '{LOAD,          11'd0,  WORD, 8'd0, 9'd508, 9'd0,   9'd0,   8'd7};
      rows[10] = '{NORMAL,        11'd64, BYTE, 8'd7, 9'd400, 9'd450, 9'd500, 8'd0};
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b1;
      @(negedge clk_i);
      assert (ready_o && !vrf_rd_o.ren && !vrf_wr_o.wen && store_o == '0 && !ready_for_load_o)
         else flag_mismatch("idle outputs wrong after reset");
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(rows[i]);
      end
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* sublane_driver.f */
design/sublane_driver_pkg.sv
design/vrf_addr_counter.sv
design/byte_enable_gen.sv
design/sublane_ctrl_fsm.sv
design/sublane_driver.sv
test/sublane_driver_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sublane_driver.f \
   --top-module sublane_driver_tb -o sublane_driver_sim > build.log 2>&1 \
   && ./obj_dir/sublane_driver_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error"
grep -q "All checks passed" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL (see build.log and sim.log)"; exit 1; }
